// File: sources.f
+incdir+design
design/core_types_pkg.sv
design/core_bus_pkg.sv
design/core_fetch.sv
design/core_mmu.sv
design/core_bus_timer.sv
design/arm810_mem.sv
testbench/tb_clock.sv
testbench/arm810_mem_assertions.sv
testbench/arm810_mem_tb.sv

// File: testbench/arm810_mem_tb.sv
`timescale 1ns/100ps
`include "core_config.svh"

module arm810_mem_tb;

	localparam int DEPTH = 1 << `PREFETCH_ORDER;
	localparam int DRAIN = 60;
	localparam int TEST_CYCLES = 5 + 200 + 600 + 600 + 800 + 700 + 5 * DRAIN;
	localparam int LIMIT = TEST_CYCLES * 12 / 10;
	localparam logic [31:0] SEED = 32'hf2cc_d273;

	logic clk, rst, stall, flush;
	logic insn_valid, data_start, data_ready, data_fault;
	logic bus_start, bus_write, bus_ready;
	core_types_pkg::ptr branch_target, insn_pc, bus_addr;
	core_types_pkg::word insn, data_data_rd, bus_data_wr, bus_data_rd;
	core_bus_pkg::bus_req data_req;

	logic [31:0] stim_seed = SEED;
	logic [31:0] mem_seed = ~SEED; // Own stream for the memory latency
	int unsigned cycle_count, checks, errors;

	// Memory model state
	core_types_pkg::word mem_array[core_types_pkg::ptr];
	core_types_pkg::ptr mem_addr;
	core_types_pkg::word mem_wdata;
	logic mem_open, mem_write;
	int unsigned mem_wait;

	// Reference model state
	core_types_pkg::ptr exp_pc, exp_addr;
	core_types_pkg::word exp_data;
	core_types_pkg::word shadow[core_types_pkg::ptr]; // Last data written per address
	logic stale; // A fetch from before the flush may still reach the bus
	logic data_busy, exp_write, exp_fault;
	int unsigned consumed, data_wait, data_issued, data_done, faults_seen;

	tb_clock u_clock (.clk(clk));

	arm810_mem u_dut
	(
		.clk(clk),
		.rst(rst),
		.stall(stall),
		.flush(flush),
		.branch_target(branch_target),
		.insn_valid(insn_valid),
		.insn(insn),
		.insn_pc(insn_pc),
		.data_start(data_start),
		.data_req(data_req),
		.data_ready(data_ready),
		.data_fault(data_fault),
		.data_data_rd(data_data_rd),
		.bus_addr(bus_addr),
		.bus_start(bus_start),
		.bus_write(bus_write),
		.bus_data_wr(bus_data_wr),
		.bus_ready(bus_ready),
		.bus_data_rd(bus_data_rd)
	);

	function automatic logic [31:0] lcg(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function int unsigned stim_below(input int unsigned n);
		stim_seed = lcg(stim_seed);
		return (stim_seed >> 8) % n;
	endfunction

	function int unsigned mem_below(input int unsigned n);
		mem_seed = lcg(mem_seed);
		return (mem_seed >> 8) % n;
	endfunction

	// Initial memory contents
	function automatic core_types_pkg::word addr_hash(input core_types_pkg::ptr a);
		return (32'(a) * 32'h9e37_79b1) ^ {a[14:0], a[29:13]} ^ 32'h5bd1_e995;
	endfunction

	function automatic core_types_pkg::word mem_read(input core_types_pkg::ptr a);
		return mem_array.exists(a) ? mem_array[a] : addr_hash(a);
	endfunction

	task automatic report_value(input string name, input logic [31:0] got, expected);
		errors++;
		$display("FAIL %s: got %h, expected %h (cycle %0d)", name, got, expected, cycle_count);
	endtask

	task automatic report_error(input string msg);
		errors++;
		$display("ERROR: %s (cycle %0d)", msg, cycle_count);
	endtask

	task automatic finish_test(input string name, input int unsigned err_before);
		if (errors == err_before)
			$display("test %s: ok", name);
		else
			$display("test %s: %0d errors", name, errors - err_before);
	endtask

	// Memory answers after 1 to 6 cycles, never inside the hole
	always @(posedge clk) begin
		#1;
		bus_ready = 1'b0;
		if (rst) begin
			mem_open = 1'b0;
		end else if (bus_start) begin
			mem_open = 1'b1;
			mem_addr = bus_addr;
			mem_write = bus_write;
			mem_wdata = bus_data_wr;
			mem_wait = 1 + mem_below(6);
		end else if (mem_open && !mem_addr[20]) begin
			mem_wait--;
			if (mem_wait == 0) begin
				if (mem_write)
					mem_array[mem_addr] = mem_wdata;
				bus_data_rd = mem_read(mem_addr);
				bus_ready = 1'b1;
				mem_open = 1'b0;
			end
		end
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > LIMIT) begin
			$display("run stopped at the cycle limit of %0d", LIMIT);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	// Outputs are sampled mid cycle
	always @(negedge clk) begin
		core_types_pkg::ptr gap;
		if (rst) begin
			if (cycle_count > 0) begin
				checks++;
				if (bus_start !== 1'b0)
					report_value("bus_start", 32'(bus_start), 32'h0);
				if (insn_valid !== 1'b0)
					report_value("insn_valid", 32'(insn_valid), 32'h0);
				if (data_ready !== 1'b0)
					report_value("data_ready", 32'(data_ready), 32'h0);
				if (data_fault !== 1'b0)
					report_value("data_fault", 32'(data_fault), 32'h0);
			end
		end else begin
			gap = bus_addr - exp_pc;
			if (bus_start && !bus_write && !bus_addr[16] && !bus_addr[20] && !stale) begin
				checks++;
				if (gap >= DEPTH)
					report_error($sformatf("fetch of %h is %0d words ahead of pc %h",
						bus_addr, gap, exp_pc));
			end

			if (flush) begin
				exp_pc = branch_target;
				stale = 1'b1;
			end else if (insn_valid && !stall) begin
				checks += 2;
				if (insn_pc !== exp_pc)
					report_value("insn_pc", 32'(insn_pc), 32'(exp_pc));
				if (insn !== mem_read(exp_pc))
					report_value("insn", insn, mem_read(exp_pc));
				exp_pc = exp_pc + 1'b1;
				consumed++;
				stale = 1'b0;
			end

			if (data_ready || data_fault) begin
				checks++;
				if (!data_busy)
					report_error("data response with no data access open");
				else if (data_fault !== exp_fault)
					report_value("data_fault", 32'(data_fault), 32'(exp_fault));
				else if (data_ready && !exp_write && data_data_rd !== exp_data)
					report_value("data_data_rd", data_data_rd, exp_data);
				if (data_fault)
					faults_seen++;
				data_busy = 1'b0;
				data_done++;
			end else if (data_busy) begin
				data_wait++;
				if (data_wait > 40) begin
					report_error($sformatf("data access to %h got no response", exp_addr));
					data_busy = 1'b0;
				end
			end
		end
	end

	task automatic start_data(input int unsigned hole_pct);
		core_types_pkg::ptr a;
		core_types_pkg::word wd;
		logic wr;
		if (stim_below(100) < hole_pct) begin
			a = 30'h10_0000 | core_types_pkg::ptr'(stim_below(256));
			wr = 1'b0;
		end else begin
			a = 30'h1_0000 + core_types_pkg::ptr'(stim_below(16));
			wr = stim_below(2) == 1;
		end
		wd = {16'(stim_below(65536)), 16'(stim_below(65536))};
		data_req = '{addr: a, write: wr, data_wr: wd};
		data_start = 1'b1;
		if (wr)
			shadow[a] = wd;
		exp_addr = a;
		exp_write = wr;
		exp_fault = a[20];
		exp_data = shadow.exists(a) ? shadow[a] : addr_hash(a);
		data_wait = 0;
		data_busy = 1'b1;
		data_issued++;
	endtask

	task automatic run_cycles(input int n, input int unsigned stall_pct, flush_pct,
		data_pct, hole_pct);
		repeat (n) begin
			@(posedge clk);
			#1;
			stall = stim_below(100) < stall_pct;
			flush = 1'b0;
			data_start = 1'b0;
			if (stim_below(100) < flush_pct) begin
				flush = 1'b1;
				branch_target = core_types_pkg::ptr'(stim_below(30'h6000));
			end
			if (!data_busy && stim_below(100) < data_pct)
				start_data(hole_pct);
		end
	endtask

	// Waits for the open data access, if any
	task automatic drain();
		int n;
		n = 0;
		do begin
			@(posedge clk);
			#1;
			stall = 1'b0;
			flush = 1'b0;
			data_start = 1'b0;
			n++;
		end while (data_busy && n < DRAIN);
		if (data_busy)
			report_error("data access still open after the test");
	endtask

	initial begin
		int unsigned err_before, start_consumed, faults_before;
		rst = 1'b1;
		stall = 1'b0;
		flush = 1'b0;
		branch_target = '0;
		data_start = 1'b0;
		data_req = '0;
		bus_ready = 1'b0;
		bus_data_rd = '0;
		exp_pc = `RESET_PC;
		stale = 1'b0;
		data_busy = 1'b0;
		mem_open = 1'b0;
		repeat (5) @(posedge clk);
		#1;
		rst = 1'b0;

		err_before = errors;
		run_cycles(200, 0, 0, 0, 0);
		drain();
		checks++;
		if (consumed < 10)
			report_error("sequential fetch made almost no progress");
		finish_test("reset and sequential fetch", err_before);

		err_before = errors;
		start_consumed = consumed;
		run_cycles(600, 50, 0, 0, 0);
		drain();
		checks++;
		if (consumed - start_consumed < 10)
			report_error("fetch made almost no progress under stall");
		finish_test("random stall", err_before);

		err_before = errors;
		run_cycles(600, 30, 5, 0, 0);
		drain();
		finish_test("flush to branch target", err_before);

		err_before = errors;
		run_cycles(800, 30, 2, 30, 0);
		drain();
		checks++;
		if (data_issued != data_done)
			report_error($sformatf("%0d data accesses got %0d responses",
				data_issued, data_done));
		finish_test("data reads and writes", err_before);

		err_before = errors;
		faults_before = faults_seen;
		run_cycles(500, 20, 2, 30, 30);
		start_consumed = consumed;
		run_cycles(200, 20, 0, 30, 0); // Normal traffic after the faults
		drain();
		checks += 3;
		if (faults_seen == faults_before)
			report_error("no access to the hole faulted");
		if (consumed - start_consumed < 10)
			report_error("fetch made almost no progress after the faults");
		if (data_issued != data_done)
			report_error($sformatf("%0d data accesses got %0d responses",
				data_issued, data_done));
		finish_test("bus fault in the hole", err_before);

		checks++;
		if (u_dut.mmu.u_assert.fails != 0)
			report_error($sformatf("bus protocol assertions failed %0d times",
				u_dut.mmu.u_assert.fails));

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// File: testbench/arm810_mem_assertions.sv
`timescale 1ns/100ps

module arm810_mem_assertions
(
	input logic               clk,
	                          rst,
	                          bus_start,
	                          bus_write,
	                          bus_ready,
	                          timeout,
	                          data_ready,
	                          insn_ready,
	input core_types_pkg::ptr bus_addr
);

	int unsigned fails; // Read by the testbench at the end of the run
	logic xfer_open;    // Started and not yet ended

	always_ff @(posedge clk) begin
		if (rst)
			xfer_open <= 1'b0;
		else if (bus_start)
			xfer_open <= 1'b1;
		else if (bus_ready || timeout)
			xfer_open <= 1'b0;
	end

	bus_stable: assert property (@(posedge clk) disable iff (rst)
		xfer_open |-> $stable({bus_addr, bus_write}))
		else begin
			fails++;
			$error("bus_addr or bus_write changed during an open transfer");
		end

	// One transfer at a time
	single_start: assert property (@(posedge clk) disable iff (rst)
		bus_start |-> !xfer_open)
		else begin
			fails++;
			$error("bus_start pulsed again before the open transfer ended");
		end

	// Every bus completion reaches exactly one requester
	ready_exclusive: assert property (@(posedge clk) disable iff (rst)
		$onehot0({insn_ready, data_ready})
		&& ((insn_ready || data_ready) == (xfer_open && bus_ready)))
		else begin
			fails++;
			$error("insn_ready and data_ready do not match the bus completion");
		end

endmodule

bind core_mmu arm810_mem_assertions u_assert (.*);

// File: testbench/tb_clock.sv
`timescale 1ns/100ps

module tb_clock
#(
	parameter real PERIOD_NS = 4.0
)
(
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2.0) clk = ~clk;
	end

endmodule

// File: design/arm810_mem.sv
`timescale 1ns/100ps
`include "core_config.svh"

module arm810_mem
(
	input  logic                 clk,
	                             rst,
	                             stall,
	                             flush,
	input  core_types_pkg::ptr   branch_target,

	output logic                 insn_valid,
	output core_types_pkg::word  insn,
	output core_types_pkg::ptr   insn_pc,

	input  logic                 data_start,
	input  core_bus_pkg::bus_req data_req,
	output logic                 data_ready,
	                             data_fault,
	output core_types_pkg::word  data_data_rd,

	output core_types_pkg::ptr   bus_addr,
	output logic                 bus_start,
	                             bus_write,
	output core_types_pkg::word  bus_data_wr,
	input  logic                 bus_ready,
	input  core_types_pkg::word  bus_data_rd
);

	core_types_pkg::ptr insn_addr;
	core_types_pkg::word insn_data_rd;
	logic insn_start, insn_ready, insn_fault;

	core_fetch #(.PREFETCH_ORDER(`PREFETCH_ORDER)) fetch
	(
		.*
	);

	logic timer_clear, busy, timeout;

	core_mmu mmu
	(
		.*
	);

	core_bus_timer timer
	(
		.*
	);

endmodule

// File: design/core_bus_timer.sv
`timescale 1ns/100ps
`include "core_config.svh"

module core_bus_timer
(
	input  logic clk,
	             rst,
	             timer_clear,
	             busy,

	output logic timeout
);

	localparam int LIMIT = `BUS_TIMEOUT;
	localparam int W = $clog2(LIMIT + 1);

	logic [W-1:0] count; // Cycles since bus_start

	// Stale count from the previous transfer is ignored on the start cycle
	assign timeout = busy && !timer_clear && count == W'(LIMIT);

	always_ff @(posedge clk) begin
		if (rst)
			count <= '0;
		else if (timer_clear)
			count <= W'(1); // Start cycle already counts
		else if (busy && count != W'(LIMIT))
			count <= count + 1'b1;
	end

endmodule

// File: design/core_mmu.sv
`timescale 1ns/100ps

module core_mmu
(
	input  logic                   clk,
	                               rst,

	input  logic                   data_start,
	input  core_bus_pkg::bus_req   data_req,
	output logic                   data_ready,
	                               data_fault,
	output core_types_pkg::word    data_data_rd,

	input  logic                   insn_start,
	input  core_types_pkg::ptr     insn_addr,
	output logic                   insn_ready,
	                               insn_fault,
	output core_types_pkg::word    insn_data_rd,

	output core_types_pkg::ptr     bus_addr,
	output logic                   bus_start,
	                               bus_write,
	output core_types_pkg::word    bus_data_wr,
	input  logic                   bus_ready,
	input  core_types_pkg::word    bus_data_rd,

	output logic                   timer_clear,
	                               busy,
	input  logic                   timeout
);

	core_bus_pkg::mmu_state state;
	core_bus_pkg::requester grant;
	core_bus_pkg::bus_req data_latch, data_sel;
	core_types_pkg::ptr insn_latch, insn_sel;
	logic data_pend, insn_pend, data_want, insn_want, finish;

	// A new pulse and a latched request count the same
	assign data_want = data_start || data_pend;
	assign insn_want = insn_start || insn_pend;
	assign data_sel = data_start ? data_req : data_latch;
	assign insn_sel = insn_start ? insn_addr : insn_latch;

	always_comb begin
		grant = core_bus_pkg::REQ_NONE;
		if (state == core_bus_pkg::IDLE) begin
			if (data_want)
				grant = core_bus_pkg::REQ_DATA; // Data first
			else if (insn_want)
				grant = core_bus_pkg::REQ_INSN;
		end
	end

	assign finish = bus_ready || timeout;

	assign data_ready = state == core_bus_pkg::DATA_WAIT && bus_ready;
	assign insn_ready = state == core_bus_pkg::INSN_WAIT && bus_ready;
	assign data_fault = state == core_bus_pkg::DATA_WAIT && timeout && !bus_ready;
	assign insn_fault = state == core_bus_pkg::INSN_WAIT && timeout && !bus_ready;

	assign data_data_rd = bus_data_rd;
	assign insn_data_rd = bus_data_rd;

	assign busy = state != core_bus_pkg::IDLE;
	assign timer_clear = bus_start; // Wait count starts with the transfer

	always_ff @(posedge clk) begin
		if (data_start)
			data_latch <= data_req;
		if (insn_start)
			insn_latch <= insn_addr;

		if (grant == core_bus_pkg::REQ_DATA) begin
			bus_addr <= data_sel.addr;
			bus_write <= data_sel.write;
			bus_data_wr <= data_sel.data_wr;
		end else if (grant == core_bus_pkg::REQ_INSN) begin
			bus_addr <= insn_sel;
			bus_write <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= core_bus_pkg::IDLE;
			data_pend <= 1'b0;
			insn_pend <= 1'b0;
			bus_start <= 1'b0;
		end else begin
			data_pend <= data_want && grant != core_bus_pkg::REQ_DATA;
			insn_pend <= insn_want && grant != core_bus_pkg::REQ_INSN;
			bus_start <= grant != core_bus_pkg::REQ_NONE;

			case (state)
				core_bus_pkg::IDLE:
					if (grant == core_bus_pkg::REQ_DATA)
						state <= core_bus_pkg::DATA_WAIT;
					else if (grant == core_bus_pkg::REQ_INSN)
						state <= core_bus_pkg::INSN_WAIT;

				core_bus_pkg::DATA_WAIT, core_bus_pkg::INSN_WAIT:
					if (finish)
						state <= core_bus_pkg::IDLE;

				default:
					state <= core_bus_pkg::IDLE;
			endcase
		end
	end

endmodule

// File: design/core_fetch.sv
`timescale 1ns/100ps
`include "core_config.svh"

module core_fetch
#(
	parameter int PREFETCH_ORDER = `PREFETCH_ORDER
)
(
	input  logic                clk,
	                            rst,
	                            stall,
	                            flush,
	input  core_types_pkg::ptr  branch_target,
	input  logic                insn_ready,
	                            insn_fault,
	input  core_types_pkg::word insn_data_rd,

	output logic                insn_start,
	output core_types_pkg::ptr  insn_addr,
	output logic                insn_valid,
	output core_types_pkg::word insn,
	output core_types_pkg::ptr  insn_pc
);

	localparam int DEPTH = 1 << PREFETCH_ORDER;

	core_types_pkg::word insn_q[DEPTH];
	core_types_pkg::ptr pc_q[DEPTH];

	core_types_pkg::queue_idx head, tail;
	core_types_pkg::ptr fetch_ptr; // Next address to request
	logic [PREFETCH_ORDER:0] count;
	logic in_flight, drop, push, pop, issue, done;

	function automatic core_types_pkg::queue_idx wrap_inc(input core_types_pkg::queue_idx idx);
		if (idx == core_types_pkg::queue_idx'(DEPTH - 1))
			return '0;
		else
			return idx + 1'b1;
	endfunction

	assign done = insn_ready || insn_fault;

	// Responses requested before a flush never enter the queue
	assign push = insn_ready && !drop && !flush;
	assign pop = insn_valid && !stall && !flush;

	// The request in flight already holds a slot
	assign issue = !in_flight && !flush && count < DEPTH;

	assign insn_valid = count != '0;
	assign insn = insn_q[head];
	assign insn_pc = pc_q[head];

	always_ff @(posedge clk) begin
		if (push) begin
			insn_q[tail] <= insn_data_rd;
			pc_q[tail] <= insn_addr;
		end

		if (issue)
			insn_addr <= fetch_ptr;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			head <= '0;
			tail <= '0;
			count <= '0;
			fetch_ptr <= `RESET_PC;
			in_flight <= 1'b0;
			drop <= 1'b0;
			insn_start <= 1'b0;
		end else begin
			insn_start <= issue;

			if (flush)
				fetch_ptr <= branch_target;
			else if (insn_fault && !drop)
				fetch_ptr <= insn_addr; // Retry the faulted word
			else if (issue)
				fetch_ptr <= fetch_ptr + 1'b1;

			if (issue)
				in_flight <= 1'b1;
			else if (done)
				in_flight <= 1'b0;

			if (done)
				drop <= 1'b0;
			else if (flush && in_flight)
				drop <= 1'b1;

			if (flush) begin
				head <= '0;
				tail <= '0;
				count <= '0;
			end else begin
				if (push)
					tail <= wrap_inc(tail);
				if (pop)
					head <= wrap_inc(head);

				if (push && !pop)
					count <= count + 1'b1;
				else if (pop && !push)
					count <= count - 1'b1;
			end
		end
	end

endmodule

// File: design/core_bus_pkg.sv
package core_bus_pkg;

	// One word transfer as issued by a requester
	typedef struct packed {
		core_types_pkg::ptr  addr;
		logic                write;
		core_types_pkg::word data_wr;
	} bus_req;

	typedef enum logic [1:0] {
		IDLE,
		DATA_WAIT, // Data transfer open
		INSN_WAIT  // Fetch transfer open
	} mmu_state;

	// Winner of the bus in an idle cycle
	typedef enum logic [1:0] {
		REQ_NONE,
		REQ_DATA,
		REQ_INSN
	} requester;

endpackage

// File: design/core_types_pkg.sv
`include "core_config.svh"

package core_types_pkg;

	// Data value on the bus and in the queue
	typedef logic [31:0] word;

	typedef logic [29:0] ptr; // Byte address without its two low bits

	// Slot in the prefetch queue
	typedef logic [`PREFETCH_ORDER-1:0] queue_idx;

endpackage

// File: design/core_config.svh
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// log2 of the prefetch queue depth
`define PREFETCH_ORDER 2

// Wait cycles before an open bus transfer is abandoned
`define BUS_TIMEOUT 16

`define RESET_PC 30'h0000_0000 // Word address of the first fetch

`endif
